//--- Makefile
# Verilator build and run for the scpuIo testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/1ps
TOP       = scpuIoTb
FILELIST  = all.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Run did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- all.f
+incdir+hw
hw/scpuIoPkg.sv
hw/wbRegDecode.sv
hw/mathUnit.sv
hw/beamCounter.sv
hw/irqControl.sv
hw/scpuIo.sv
verification/tbClock.sv
verification/scpuIoTb.sv

//--- hw/beamCounter.sv
`include "scpuIo_macros.svh"

module beamCounter (
    input  logic                   CLK,
    input  logic                   RST_N,
    input  logic                   HBLANK,
    input  logic                   VBLANK,
    output logic                   dotCe,
    output scpuIoPkg::beamCount_t  hCount,
    output scpuIoPkg::beamCount_t  vCount
);

    localparam int DotCntW = $clog2(`DOT_DIV);

    logic [DotCntW-1:0] dotCnt;
    logic               dotLast;
    logic               hblankOld;
    logic               vblankOld;
    logic               hFall;
    logic               vFall;

    assign dotLast = (dotCnt == DotCntW'(`DOT_DIV - 1));
    assign hFall   = hblankOld & ~HBLANK;   // End of line blanking
    assign vFall   = vblankOld & ~VBLANK;   // End of frame blanking

    always_ff @(posedge CLK) begin
        if (!RST_N) begin
            dotCnt    <= '0;
            dotCe     <= 1'b0;
            hblankOld <= 1'b0;
            vblankOld <= 1'b0;
            hCount    <= '0;
            vCount    <= '0;
        end else begin
            dotCnt    <= dotLast ? '0 : dotCnt + DotCntW'(1);
            dotCe     <= dotLast;
            hblankOld <= HBLANK;
            vblankOld <= VBLANK;

            if (vFall) begin
                hCount <= '0;
                vCount <= '0;
            end else if (hFall) begin
                hCount <= '0;
                vCount <= vCount + 9'd1;
            end else if (dotCe) begin
                hCount <= hCount + 9'd1;
            end
        end
    end

endmodule

//--- hw/irqControl.sv
`include "scpuIo_macros.svh"

module irqControl (
    input  logic                   CLK,
    input  logic                   RST_N,
    input  scpuIoPkg::byte_t       wrData,
    input  logic                   nmitimenWr,
    input  logic                   htimeLoWr,
    input  logic                   htimeHiWr,
    input  logic                   vtimeLoWr,
    input  logic                   vtimeHiWr,
    input  logic                   rdnmiRd,
    input  logic                   timeupRd,
    input  logic                   dotCe,
    input  scpuIoPkg::beamCount_t  hCount,
    input  scpuIoPkg::beamCount_t  vCount,
    input  logic                   VBLANK,
    output logic                   nmiFlag,
    output logic                   irqFlag,
    output logic                   NMI_N,
    output logic                   IRQ_N
);

    logic                   nmiEn;
    scpuIoPkg::irqMode_t    irqMode;
    scpuIoPkg::beamCount_t  hTime;
    scpuIoPkg::beamCount_t  vTime;
    logic                   vblankDot;   // VBLANK as of the last dot
    logic                   nmiLock;     // Flag set during the current dot
    logic                   irqMatch;
    logic                   matchOld;
    logic                   irqOff;

    assign irqOff = nmitimenWr && (wrData[5:4] == 2'b00);

    always_ff @(posedge CLK) begin
        if (!RST_N) begin
            nmiEn   <= 1'b0;
            irqMode <= scpuIoPkg::IRQ_OFF;
            hTime   <= `TIME_RESET;
            vTime   <= `TIME_RESET;
        end else begin
            if (nmitimenWr) begin
                nmiEn   <= wrData[7];
                irqMode <= scpuIoPkg::irqMode_t'(wrData[5:4]);
            end
            if (htimeLoWr) hTime[7:0] <= wrData;
            if (htimeHiWr) hTime[8]   <= wrData[0];
            if (vtimeLoWr) vTime[7:0] <= wrData;
            if (vtimeHiWr) vTime[8]   <= wrData[0];
        end
    end

    // NMI flag, a read in the dot that set it does not clear it
    always_ff @(posedge CLK) begin
        if (!RST_N) begin
            nmiFlag   <= 1'b0;
            nmiLock   <= 1'b0;
            vblankDot <= 1'b0;
        end else begin
            if (dotCe) begin
                vblankDot <= VBLANK;
                nmiLock   <= 1'b0;
            end
            if (dotCe && VBLANK && !vblankDot) begin
                nmiFlag <= 1'b1;
                nmiLock <= 1'b1;
            end else if (dotCe && !VBLANK && vblankDot) begin
                nmiFlag <= 1'b0;
            end else if (rdnmiRd && !nmiLock) begin
                nmiFlag <= 1'b0;
            end
        end
    end

    always_comb begin
        case (irqMode)
            scpuIoPkg::IRQ_H:  irqMatch = (hCount == hTime);
            scpuIoPkg::IRQ_V:  irqMatch = (vCount == vTime) && (hCount == '0);
            scpuIoPkg::IRQ_HV: irqMatch = (hCount == hTime) && (vCount == vTime);
            default:           irqMatch = 1'b0;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (!RST_N) begin
            irqFlag  <= 1'b0;
            matchOld <= 1'b0;
        end else begin
            if (dotCe) begin
                matchOld <= irqMatch;
            end
            if (irqOff) begin
                irqFlag <= 1'b0;   // Disabling the timer drops a pending IRQ
            end else if (dotCe && irqMatch && !matchOld) begin
                irqFlag <= 1'b1;
            end else if (timeupRd) begin
                irqFlag <= 1'b0;
            end
        end
    end

    assign NMI_N = ~(nmiEn & nmiFlag);
    assign IRQ_N = ~irqFlag;

endmodule

//--- hw/mathUnit.sv
`include "scpuIo_macros.svh"

module mathUnit (
    input  logic              CLK,
    input  logic              RST_N,
    input  scpuIoPkg::byte_t  wrData,
    input  logic              mpyAWr,
    input  logic              mpyBWr,
    input  logic              divLoWr,
    input  logic              divHiWr,
    input  logic              divBWr,
    output scpuIoPkg::word_t  rdDiv,
    output scpuIoPkg::word_t  rdMpy
);

    scpuIoPkg::mathState_t state;
    logic [3:0]            stepCnt;
    scpuIoPkg::byte_t      mpyA;      // WRMPYA
    scpuIoPkg::word_t      divA;      // WRDIVA
    logic [22:0]           shiftOp;   // Multiplicand, or divisor aligned to bit 15
    logic                  mulStart;
    logic                  divStart;
    logic                  lastStep;

    // Starts while busy are dropped
    assign mulStart = mpyBWr && (state == scpuIoPkg::MATH_IDLE);
    assign divStart = divBWr && (state == scpuIoPkg::MATH_IDLE);

    always_comb begin
        if (state == scpuIoPkg::MATH_MUL) begin
            lastStep = (stepCnt == 4'(`MUL_STEPS - 1));
        end else begin
            lastStep = (stepCnt == 4'(`DIV_STEPS - 1));
        end
    end

    always_ff @(posedge CLK) begin
        if (mpyAWr) begin
            mpyA <= wrData;
        end
        if (divLoWr) begin
            divA[7:0] <= wrData;
        end
        if (divHiWr) begin
            divA[15:8] <= wrData;
        end

        if (mulStart) begin
            shiftOp <= {15'b0, wrData};
        end else if (divStart) begin
            shiftOp <= {wrData, 15'b0};
        end else if (state == scpuIoPkg::MATH_MUL) begin
            shiftOp <= {shiftOp[21:0], 1'b0};
        end else if (state == scpuIoPkg::MATH_DIV) begin
            shiftOp <= {1'b0, shiftOp[22:1]};
        end
    end

    always_ff @(posedge CLK) begin
        if (!RST_N) begin
            state   <= scpuIoPkg::MATH_IDLE;
            stepCnt <= '0;
            rdDiv   <= '0;
            rdMpy   <= '0;
        end else begin
            case (state)
                scpuIoPkg::MATH_IDLE: begin
                    stepCnt <= '0;
                    if (mulStart) begin
                        rdDiv <= {wrData, mpyA};   // Multiplier leaves from bit 0, B remains
                        rdMpy <= '0;
                        state <= scpuIoPkg::MATH_MUL;
                    end else if (divStart) begin
                        rdMpy <= divA;             // Running remainder
                        state <= scpuIoPkg::MATH_DIV;
                    end
                end
                scpuIoPkg::MATH_MUL: begin
                    if (rdDiv[0]) begin
                        rdMpy <= rdMpy + shiftOp[15:0];
                    end
                    rdDiv   <= {1'b0, rdDiv[15:1]};
                    stepCnt <= stepCnt + 4'd1;
                    if (lastStep) begin
                        state <= scpuIoPkg::MATH_IDLE;
                    end
                end
                scpuIoPkg::MATH_DIV: begin
                    // Restoring step, zero divisor always subtracts and gives FFFF
                    if ({7'b0, rdMpy} >= shiftOp) begin
                        rdMpy <= rdMpy - shiftOp[15:0];
                        rdDiv <= {rdDiv[14:0], 1'b1};
                    end else begin
                        rdDiv <= {rdDiv[14:0], 1'b0};
                    end
                    stepCnt <= stepCnt + 4'd1;
                    if (lastStep) begin
                        state <= scpuIoPkg::MATH_IDLE;
                    end
                end
                default: state <= scpuIoPkg::MATH_IDLE;
            endcase
        end
    end

endmodule

//--- hw/scpuIo.sv
module scpuIo (
    input  logic                CLK,
    input  logic                RST_N,
    input  logic                wbCyc,
    input  logic                wbStb,
    input  logic                wbWe,
    input  scpuIoPkg::regOfs_t  wbAdr,
    input  scpuIoPkg::byte_t    wbDatW,
    output scpuIoPkg::byte_t    wbDatR,
    output logic                wbAck,
    input  logic                HBLANK,
    input  logic                VBLANK,
    output logic                NMI_N,
    output logic                IRQ_N
);

    scpuIoPkg::byte_t       wrData;
    scpuIoPkg::word_t       rdDiv;
    scpuIoPkg::word_t       rdMpy;
    scpuIoPkg::beamCount_t  hCount;
    scpuIoPkg::beamCount_t  vCount;
    logic                   dotCe;
    logic                   nmiFlag;
    logic                   irqFlag;
    logic                   nmitimenWr;
    logic                   htimeLoWr;
    logic                   htimeHiWr;
    logic                   vtimeLoWr;
    logic                   vtimeHiWr;
    logic                   rdnmiRd;
    logic                   timeupRd;
    logic                   mpyAWr;
    logic                   mpyBWr;
    logic                   divLoWr;
    logic                   divHiWr;
    logic                   divBWr;

    wbRegDecode wbRegDecode_i (
        .CLK(CLK), .RST_N(RST_N),
        .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr), .wbDatW(wbDatW),
        .wbDatR(wbDatR), .wbAck(wbAck),
        .HBLANK(HBLANK), .VBLANK(VBLANK), .nmiFlag(nmiFlag), .irqFlag(irqFlag),
        .rdDiv(rdDiv), .rdMpy(rdMpy), .wrData(wrData),
        .nmitimenWr(nmitimenWr), .htimeLoWr(htimeLoWr), .htimeHiWr(htimeHiWr),
        .vtimeLoWr(vtimeLoWr), .vtimeHiWr(vtimeHiWr),
        .rdnmiRd(rdnmiRd), .timeupRd(timeupRd),
        .mpyAWr(mpyAWr), .mpyBWr(mpyBWr),
        .divLoWr(divLoWr), .divHiWr(divHiWr), .divBWr(divBWr)
    );

    mathUnit mathUnit_i (
        .CLK(CLK), .RST_N(RST_N), .wrData(wrData),
        .mpyAWr(mpyAWr), .mpyBWr(mpyBWr),
        .divLoWr(divLoWr), .divHiWr(divHiWr), .divBWr(divBWr),
        .rdDiv(rdDiv), .rdMpy(rdMpy)
    );

    beamCounter beamCounter_i (
        .CLK(CLK), .RST_N(RST_N), .HBLANK(HBLANK), .VBLANK(VBLANK),
        .dotCe(dotCe), .hCount(hCount), .vCount(vCount)
    );

    irqControl irqControl_i (
        .CLK(CLK), .RST_N(RST_N), .wrData(wrData),
        .nmitimenWr(nmitimenWr), .htimeLoWr(htimeLoWr), .htimeHiWr(htimeHiWr),
        .vtimeLoWr(vtimeLoWr), .vtimeHiWr(vtimeHiWr),
        .rdnmiRd(rdnmiRd), .timeupRd(timeupRd),
        .dotCe(dotCe), .hCount(hCount), .vCount(vCount), .VBLANK(VBLANK),
        .nmiFlag(nmiFlag), .irqFlag(irqFlag), .NMI_N(NMI_N), .IRQ_N(IRQ_N)
    );

endmodule

//--- hw/scpuIoPkg.sv
package scpuIoPkg;

    typedef logic [7:0]  byte_t;      // Register data
    typedef logic [15:0] word_t;      // Math operands and results
    typedef logic [7:0]  regOfs_t;    // Offset within $42xx
    typedef logic [8:0]  beamCount_t;

    // Encoding matches NMITIMEN bits 5:4
    typedef enum logic [1:0] {
        IRQ_OFF = 2'b00,
        IRQ_H   = 2'b01,
        IRQ_V   = 2'b10,
        IRQ_HV  = 2'b11
    } irqMode_t;

    typedef enum logic [1:0] {
        MATH_IDLE,
        MATH_MUL,
        MATH_DIV
    } mathState_t;

endpackage

//--- hw/scpuIo_macros.svh
`ifndef SCPUIO_MACROS_SVH
`define SCPUIO_MACROS_SVH

// Register offsets, low byte of the $42xx page
`define NMITIMEN_OFS 8'h00
`define WRMPYA_OFS   8'h02
`define WRMPYB_OFS   8'h03
`define WRDIVL_OFS   8'h04
`define WRDIVH_OFS   8'h05
`define WRDIVB_OFS   8'h06
`define HTIMEL_OFS   8'h07
`define HTIMEH_OFS   8'h08
`define VTIMEL_OFS   8'h09
`define VTIMEH_OFS   8'h0A
`define RDNMI_OFS    8'h10
`define TIMEUP_OFS   8'h11
`define HVBJOY_OFS   8'h12
`define RDDIVL_OFS   8'h14
`define RDDIVH_OFS   8'h15
`define RDMPYL_OFS   8'h16
`define RDMPYH_OFS   8'h17

`define MUL_STEPS      8        // One CLK per add-and-shift
`define DIV_STEPS      16
`define DOT_DIV        4        // CLKs per dot
`define CPU_VERSION    4'h2     // Low nibble of RDNMI
`define OPEN_BUS_RESET 8'hFF
`define TIME_RESET     9'h1FF   // HTIME and VTIME after reset

`endif

//--- hw/wbRegDecode.sv
`include "scpuIo_macros.svh"

module wbRegDecode (
    input  logic                CLK,
    input  logic                RST_N,
    input  logic                wbCyc,
    input  logic                wbStb,
    input  logic                wbWe,
    input  scpuIoPkg::regOfs_t  wbAdr,
    input  scpuIoPkg::byte_t    wbDatW,
    output scpuIoPkg::byte_t    wbDatR,
    output logic                wbAck,
    input  logic                HBLANK,
    input  logic                VBLANK,
    input  logic                nmiFlag,
    input  logic                irqFlag,
    input  scpuIoPkg::word_t    rdDiv,
    input  scpuIoPkg::word_t    rdMpy,
    output scpuIoPkg::byte_t    wrData,
    output logic                nmitimenWr,
    output logic                htimeLoWr,
    output logic                htimeHiWr,
    output logic                vtimeLoWr,
    output logic                vtimeHiWr,
    output logic                rdnmiRd,
    output logic                timeupRd,
    output logic                mpyAWr,
    output logic                mpyBWr,
    output logic                divLoWr,
    output logic                divHiWr,
    output logic                divBWr
);

    scpuIoPkg::byte_t openBus;   // Last byte seen on the bus
    scpuIoPkg::byte_t readData;
    logic             accept;
    logic             wrAcc;
    logic             rdAcc;

    // Sampled transfer, ack follows on the next edge
    assign accept = wbCyc & wbStb & ~wbAck;
    assign wrAcc  = accept & wbWe;
    assign rdAcc  = accept & ~wbWe;
    assign wrData = wbDatW;

    always_ff @(posedge CLK) begin
        if (!RST_N) begin
            wbAck <= 1'b0;
        end else begin
            wbAck <= accept;   // Drops after one cycle since accept needs ~wbAck
        end
    end

    assign nmitimenWr = wrAcc && (wbAdr == `NMITIMEN_OFS);
    assign mpyAWr     = wrAcc && (wbAdr == `WRMPYA_OFS);
    assign mpyBWr     = wrAcc && (wbAdr == `WRMPYB_OFS);
    assign divLoWr    = wrAcc && (wbAdr == `WRDIVL_OFS);
    assign divHiWr    = wrAcc && (wbAdr == `WRDIVH_OFS);
    assign divBWr     = wrAcc && (wbAdr == `WRDIVB_OFS);
    assign htimeLoWr  = wrAcc && (wbAdr == `HTIMEL_OFS);
    assign htimeHiWr  = wrAcc && (wbAdr == `HTIMEH_OFS);
    assign vtimeLoWr  = wrAcc && (wbAdr == `VTIMEL_OFS);
    assign vtimeHiWr  = wrAcc && (wbAdr == `VTIMEH_OFS);
    assign rdnmiRd    = rdAcc && (wbAdr == `RDNMI_OFS);
    assign timeupRd   = rdAcc && (wbAdr == `TIMEUP_OFS);

    always_comb begin
        case (wbAdr)
            `RDNMI_OFS:  readData = {nmiFlag, openBus[6:4], `CPU_VERSION};
            `TIMEUP_OFS: readData = {irqFlag, openBus[6:0]};
            `HVBJOY_OFS: readData = {VBLANK, HBLANK, openBus[5:1], 1'b0};
            `RDDIVL_OFS: readData = rdDiv[7:0];
            `RDDIVH_OFS: readData = rdDiv[15:8];
            `RDMPYL_OFS: readData = rdMpy[7:0];
            `RDMPYH_OFS: readData = rdMpy[15:8];
            default:     readData = openBus;   // Unmapped reads float
        endcase
    end

    always_ff @(posedge CLK) begin
        if (!RST_N) begin
            openBus <= `OPEN_BUS_RESET;
        end else if (wrAcc) begin
            openBus <= wbDatW;
        end else if (rdAcc) begin
            openBus <= readData;
        end
    end

    // Latch holds the returned byte while wbAck is high
    assign wbDatR = openBus;

endmodule

//--- verification/scpuIoTb.sv
`include "scpuIo_macros.svh"

module scpuIoTb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int BusTimeout   = 8;
    localparam int EventTimeout = 2 * `DOT_DIV + 2;   // Longest flag latency
    localparam int ResetTimeout = 20;
    localparam int HirqLimit    = (10 + 2) * `DOT_DIV;

    logic                CLK;
    logic                RST_N;
    logic                wbCyc;
    logic                wbStb;
    logic                wbWe;
    scpuIoPkg::regOfs_t  wbAdr;
    scpuIoPkg::byte_t    wbDatW;
    scpuIoPkg::byte_t    wbDatR;
    logic                wbAck;
    logic                HBLANK;
    logic                VBLANK;
    logic                NMI_N;
    logic                IRQ_N;

    integer seed = 32'h72c15c2d;
    int     errorCount = 0;
    int     testsRun = 0;
    int     testsFailed = 0;
    int     testErrBase = 0;
    int     lastAckWait = 0;   // Cycles between strobe and ack
    int     cycleCount = 0;
    logic   ackAfter;
    string  testName = "startup";

    tbClock clockGen (.CLK(CLK), .RST_N(RST_N));

    scpuIo scpuIo_i (
        .CLK(CLK), .RST_N(RST_N),
        .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr), .wbDatW(wbDatW),
        .wbDatR(wbDatR), .wbAck(wbAck),
        .HBLANK(HBLANK), .VBLANK(VBLANK), .NMI_N(NMI_N), .IRQ_N(IRQ_N)
    );

    always @(posedge CLK) cycleCount <= cycleCount + 1;

    task automatic reportFailure(input string what);
        $display("%s: %s", testName, what);
        errorCount++;
    endtask

    task automatic checkByte(input string label, input scpuIoPkg::byte_t expected,
                             input scpuIoPkg::byte_t actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: %s expected %h, got %h", testName, label, expected, actual);
            errorCount++;
        end
    endtask

    task automatic checkWord(input string label, input scpuIoPkg::word_t expected,
                             input scpuIoPkg::word_t actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: %s expected %h, got %h", testName, label, expected, actual);
            errorCount++;
        end
    endtask

    task automatic checkBit(input string label, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: %s expected %b, got %b", testName, label, expected, actual);
            errorCount++;
        end
    endtask

    task automatic startTest(input string name);
        testName    = name;
        testErrBase = errorCount;
        testsRun++;
    endtask

    task automatic endTest();
        if (errorCount == testErrBase) begin
            $display("Test %s passed", testName);
        end else begin
            testsFailed++;
            $display("Test %s FAILED with %0d errors", testName, errorCount - testErrBase);
        end
    endtask

    // Master side of one classic cycle, strobe already driven
    task automatic waitAck(output bit acked, output scpuIoPkg::byte_t data);
        int waitCnt;
        waitCnt = 0;
        acked   = 1'b0;
        data    = '0;
        while (!acked && waitCnt < BusTimeout) begin
            @(negedge CLK);
            if (wbAck) begin
                acked = 1'b1;
                data  = wbDatR;
            end else begin
                waitCnt++;
            end
        end
        lastAckWait = waitCnt;
        @(posedge CLK);
        wbCyc <= 1'b0;
        wbStb <= 1'b0;
        @(negedge CLK);
        ackAfter = wbAck;   // Low again if ack lasted one cycle
    endtask

    task automatic wbWrite(input scpuIoPkg::regOfs_t adr, input scpuIoPkg::byte_t data);
        bit               acked;
        scpuIoPkg::byte_t unused;
        @(posedge CLK);
        wbCyc  <= 1'b1;
        wbStb  <= 1'b1;
        wbWe   <= 1'b1;
        wbAdr  <= adr;
        wbDatW <= data;
        waitAck(acked, unused);
        if (!acked) reportFailure($sformatf("no wbAck for the write to offset %h", adr));
    endtask

    task automatic wbRead(input scpuIoPkg::regOfs_t adr, output scpuIoPkg::byte_t data);
        bit acked;
        @(posedge CLK);
        wbCyc <= 1'b1;
        wbStb <= 1'b1;
        wbWe  <= 1'b0;
        wbAdr <= adr;
        waitAck(acked, data);
        if (!acked) reportFailure($sformatf("no wbAck for the read of offset %h", adr));
    endtask

    task automatic readWord(input scpuIoPkg::regOfs_t loOfs, output scpuIoPkg::word_t value);
        scpuIoPkg::byte_t lo;
        scpuIoPkg::byte_t hi;
        wbRead(loOfs, lo);
        wbRead(loOfs + 8'd1, hi);
        value = {hi, lo};
    endtask

    task automatic driveBlank(input bit vert, input logic level);
        @(posedge CLK);
        if (vert) VBLANK <= level;
        else HBLANK <= level;
    endtask

    task automatic pulseBlank(input bit vert);
        driveBlank(vert, 1'b1);
        driveBlank(vert, 1'b0);   // Falling edge does the work
    endtask

    task automatic waitForLow(input bit pickIrq, input int limit);
        int cnt;
        bit seen;
        cnt  = 0;
        seen = 1'b0;
        while (!seen && cnt < limit) begin
            @(negedge CLK);
            if ((pickIrq && !IRQ_N) || (!pickIrq && !NMI_N)) seen = 1'b1;
            else cnt++;
        end
        if (!seen) begin
            reportFailure($sformatf("%s stayed high for %0d cycles",
                                    pickIrq ? "IRQ_N" : "NMI_N", limit));
        end
    endtask

    task automatic resetAndBus();
        scpuIoPkg::byte_t data;
        startTest("reset_bus");
        @(negedge CLK);
        checkBit("NMI_N after reset", 1'b1, NMI_N);
        checkBit("IRQ_N after reset", 1'b1, IRQ_N);
        checkBit("wbAck after reset", 1'b0, wbAck);
        wbRead(`RDNMI_OFS, data);
        checkByte("RDNMI", 8'h72, data);   // Flag 0, open bus 111, version 2
        checkByte("ack wait cycles", 8'd1, 8'(lastAckWait));
        checkBit("wbAck one cycle", 1'b0, ackAfter);
        wbRead(8'h30, data);
        checkByte("open bus after read", 8'h72, data);
        wbWrite(8'h31, 8'hA5);
        wbRead(8'h30, data);
        checkByte("open bus after write", 8'hA5, data);
        endTest();
    endtask

    task automatic multiplyPairs();
        int               i;
        int               tmp;
        scpuIoPkg::byte_t a;
        scpuIoPkg::byte_t b;
        scpuIoPkg::word_t prod;
        scpuIoPkg::word_t other;
        startTest("multiply");
        for (i = 0; i < 20; i++) begin
            tmp = $random(seed);
            a   = tmp[7:0];
            b   = tmp[15:8];
            wbWrite(`WRMPYA_OFS, a);
            wbWrite(`WRMPYB_OFS, b);
            repeat (`MUL_STEPS + 1) @(posedge CLK);
            readWord(`RDMPYL_OFS, prod);
            readWord(`RDDIVL_OFS, other);
            checkWord($sformatf("RDMPY %h*%h", a, b), {8'h00, a} * {8'h00, b}, prod);
            checkWord($sformatf("RDDIV %h*%h", a, b), {8'h00, b}, other);
        end
        endTest();
    endtask

    task automatic dividePairs();
        int               i;
        int               tmp;
        scpuIoPkg::word_t dividend;
        scpuIoPkg::byte_t divisor;
        scpuIoPkg::word_t expQ;
        scpuIoPkg::word_t expR;
        scpuIoPkg::word_t quot;
        scpuIoPkg::word_t rem;
        startTest("divide");
        for (i = 0; i <= 20; i++) begin
            tmp      = $random(seed);
            dividend = tmp[15:0];
            divisor  = tmp[23:16];
            if (i == 20) divisor = 8'h00;   // Last pass divides by zero
            if (divisor == 8'h00) begin
                expQ = 16'hFFFF;
                expR = dividend;
            end else begin
                expQ = dividend / {8'h00, divisor};
                expR = dividend % {8'h00, divisor};
            end
            wbWrite(`WRDIVL_OFS, dividend[7:0]);
            wbWrite(`WRDIVH_OFS, dividend[15:8]);
            wbWrite(`WRDIVB_OFS, divisor);
            repeat (`DIV_STEPS + 1) @(posedge CLK);
            readWord(`RDDIVL_OFS, quot);
            readWord(`RDMPYL_OFS, rem);
            checkWord($sformatf("quotient %h/%h", dividend, divisor), expQ, quot);
            checkWord($sformatf("remainder %h/%h", dividend, divisor), expR, rem);
        end
        endTest();
    endtask

    task automatic nmiSequence();
        scpuIoPkg::byte_t data;
        startTest("nmi");
        wbWrite(`NMITIMEN_OFS, 8'h80);
        driveBlank(1'b1, 1'b1);
        waitForLow(1'b0, EventTimeout);
        repeat (`DOT_DIV + 1) @(posedge CLK);   // Past the dot that set the flag
        wbRead(`RDNMI_OFS, data);
        checkBit("RDNMI bit 7 first read", 1'b1, data[7]);
        wbRead(`RDNMI_OFS, data);
        checkBit("RDNMI bit 7 second read", 1'b0, data[7]);
        checkBit("NMI_N after reads", 1'b1, NMI_N);
        driveBlank(1'b1, 1'b0);
        wbWrite(`NMITIMEN_OFS, 8'h00);
        endTest();
    endtask

    task automatic vIrqSequence();
        scpuIoPkg::byte_t data;
        startTest("v_irq");
        pulseBlank(1'b1);   // V and H back to zero
        wbWrite(`VTIMEH_OFS, 8'h00);
        wbWrite(`VTIMEL_OFS, 8'h03);
        wbWrite(`NMITIMEN_OFS, 8'h20);
        repeat (3) pulseBlank(1'b0);
        waitForLow(1'b1, EventTimeout);
        wbRead(`TIMEUP_OFS, data);
        checkBit("TIMEUP bit 7 first read", 1'b1, data[7]);
        wbRead(`TIMEUP_OFS, data);
        checkBit("TIMEUP bit 7 second read", 1'b0, data[7]);
        checkBit("IRQ_N after reads", 1'b1, IRQ_N);

        // Same line again, cleared by switching the timer off
        pulseBlank(1'b1);
        repeat (3) pulseBlank(1'b0);
        waitForLow(1'b1, EventTimeout);
        wbWrite(`NMITIMEN_OFS, 8'h00);
        checkBit("IRQ_N after IRQ_OFF", 1'b1, IRQ_N);
        endTest();
    endtask

    task automatic hIrqSequence();
        int               startCycle;
        scpuIoPkg::byte_t data;
        startTest("h_irq");
        wbWrite(`NMITIMEN_OFS, 8'h10);   // HTIME still out of reach here
        pulseBlank(1'b0);
        @(negedge CLK);
        startCycle = cycleCount;
        wbWrite(`HTIMEH_OFS, 8'h00);
        wbWrite(`HTIMEL_OFS, 8'd10);
        waitForLow(1'b1, HirqLimit - (cycleCount - startCycle));
        wbRead(`TIMEUP_OFS, data);
        checkBit("TIMEUP bit 7", 1'b1, data[7]);
        wbWrite(`NMITIMEN_OFS, 8'h00);
        endTest();
    endtask

    initial begin
        int waitCnt;
        wbCyc  = 1'b0;
        wbStb  = 1'b0;
        wbWe   = 1'b0;
        wbAdr  = '0;
        wbDatW = '0;
        HBLANK = 1'b0;
        VBLANK = 1'b0;

        waitCnt = 0;
        while (RST_N !== 1'b1 && waitCnt < ResetTimeout) begin
            @(negedge CLK);
            waitCnt++;
        end
        if (RST_N !== 1'b1) reportFailure("reset was never released");

        resetAndBus();
        multiplyPairs();
        dividePairs();
        nmiSequence();
        vIrqSequence();
        hIrqSequence();

        $display("Tests run %0d, tests failed %0d, check errors %0d",
                 testsRun, testsFailed, errorCount);
        if (errorCount == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Whole-run limit in case a loop above never ends
    initial begin
        #200000;
        $display("Run stopped after 200 us without finishing");
        $display("Simulation failed");
        $finish;
    end

endmodule

//--- verification/tbClock.sv
module tbClock (
    output logic CLK,
    output logic RST_N
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;   // 10 ns period
    end

    // Reset seen low on three rising edges
    initial begin
        RST_N = 1'b0;
        repeat (3) @(posedge CLK);
        RST_N <= 1'b1;
    end

endmodule
